/* design/gc_pkg.sv */
// Global control package
// Shared widths, instruction encodings, privilege levels, exception
// causes and the control state enumeration for the machine/user build
`default_nettype none

package gc_pkg;

    ////////////////////////////////////////
    // Widths and counts
    localparam int unsigned XLEN = 32;

    // External sources, local source sits at index 0
    localparam int unsigned NUM_EXT_EXCEPTIONS = 3;
    localparam int unsigned NUM_EXCEPTIONS = NUM_EXT_EXCEPTIONS + 1;
    localparam int unsigned EXC_SRC_W = $clog2(NUM_EXCEPTIONS);
    localparam int unsigned EXC_CODE_W = 5;

    // Entries swept by the post-reset clear
    localparam int unsigned INIT_CLEAR_DEPTH = 64;
    // Extra top bit flags the end of the sweep
    localparam int unsigned INIT_CNT_W = $clog2(INIT_CLEAR_DEPTH) + 1;

    ////////////////////////////////////////
    // Exception causes
    typedef logic [EXC_CODE_W-1:0] exc_code_t;

    localparam exc_code_t CODE_INST_MISALIGNED = 5'd0;
    localparam exc_code_t CODE_INST_FAULT = 5'd1;
    localparam exc_code_t CODE_ILLEGAL_INST = 5'd2;
    localparam exc_code_t CODE_BREAKPOINT = 5'd3;
    localparam exc_code_t CODE_LOAD_FAULT = 5'd5;
    localparam exc_code_t CODE_STORE_FAULT = 5'd7;
    localparam exc_code_t CODE_ECALL_U = 5'd8;
    localparam exc_code_t CODE_ECALL_M = 5'd11;

    ////////////////////////////////////////
    // Instruction encodings
    // MRET and WFI are matched on the whole word
    localparam logic [XLEN-1:0] INSTR_MRET = 32'h3020_0073;
    localparam logic [XLEN-1:0] INSTR_WFI = 32'h1050_0073;
    // FENCE.I only compares opcode and funct3
    localparam logic [XLEN-1:0] INSTR_FENCE_I = 32'h0000_100f;

    // Privilege levels kept by this core
    typedef enum logic [1:0] {
        PRIV_USER = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_t;

    // Control FSM states
    typedef enum logic [2:0] {
        RST, PRE_CLEAR, INIT_CLEAR, IDLE, WAIT_INTERRUPT, PRE_ISSUE_FLUSH, WAIT_WRITE
    } gc_state_t;

endpackage

`default_nettype wire

/* design/gc_decode.sv */
// Global control decode
// Recognizes MRET, WFI and FENCE.I in the decode-stage word, raises
// unit_needed for them and latches the per-instruction flags as the
// issue stage takes the instruction
`timescale 1ns/1ps
`default_nettype none

module gc_decode
    import gc_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] decode_instruction,
    input  logic            issue_stage_ready,
    output logic            unit_needed,
    output logic            is_mret_d,
    output logic            is_wfi_d,
    output logic            is_ifence_d
);

    logic match_mret;
    logic match_wfi;
    logic match_ifence;

    ////////////////////////////////////////
    // Encoding match
    // Returns need the exact word
    assign match_mret = (decode_instruction == INSTR_MRET);
    assign match_wfi = (decode_instruction == INSTR_WFI);

    // FENCE.I ignores rd, rs1 and imm fields
    assign match_ifence = (decode_instruction[6:0] == INSTR_FENCE_I[6:0]) &&
                          (decode_instruction[14:12] == INSTR_FENCE_I[14:12]);

    assign unit_needed = match_mret | match_wfi | match_ifence;

    ////////////////////////////////////////
    // Flags for the issue stage
    // Only updated when issue accepts a new instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            is_mret_d <= 1'b0;
            is_wfi_d <= 1'b0;
            is_ifence_d <= 1'b0;
        end else if (issue_stage_ready) begin
            is_mret_d <= match_mret;
            is_wfi_d <= match_wfi;
            is_ifence_d <= match_ifence;
        end
    end

endmodule

`default_nettype wire

/* design/gc_issue_check.sv */
// Global control issue check
// Traps MRET issued from user mode as an illegal instruction and keeps
// the offending word and PC as the trap record; otherwise produces the
// one-cycle issued pulses for MRET and FENCE.I
`timescale 1ns/1ps
`default_nettype none

module gc_issue_check
    import gc_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            issue_new_request,
    input  logic            is_mret_d,
    input  logic            is_ifence_d,
    input  priv_t           privilege,
    input  logic [XLEN-1:0] issue_instruction,
    input  logic [XLEN-1:0] issue_pc,
    output logic            new_exception,
    output logic            mret,
    output logic            ifence_r,
    output logic            fetch_ifence,
    output logic            local_exc_valid,
    output logic [XLEN-1:0] local_exc_tval,
    output logic [XLEN-1:0] local_exc_pc
);

    ////////////////////////////////////////
    // Privilege check
    // Only MRET is privileged in the M/U build
    assign new_exception = issue_new_request & is_mret_d & (privilege == PRIV_USER);

    ////////////////////////////////////////
    // Issued pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            mret <= 1'b0;
            ifence_r <= 1'b0;
            fetch_ifence <= 1'b0;
            local_exc_valid <= 1'b0;
        end else begin
            // Suppressed when the same issue traps
            mret <= issue_new_request & is_mret_d & ~new_exception;
            ifence_r <= issue_new_request & is_ifence_d & ~new_exception;
            // Fetch side invalidate follows the issue alone
            fetch_ifence <= issue_new_request & is_ifence_d;
            local_exc_valid <= new_exception;
        end
    end

    // Trap record, captured with every issue
    always_ff @(posedge clk) begin
        if (issue_new_request) begin
            local_exc_tval <= issue_instruction;
            local_exc_pc <= issue_pc;
        end
    end

endmodule

`default_nettype wire

/* design/gc_exception_arbiter.sv */
// Global control exception arbiter
// Merges the local source and the external sources into one exception
// record; valids are one-hot, so the selected index is a plain encode
// Also reduces the possible-exception flags into the stall level
`timescale 1ns/1ps
`default_nettype none

module gc_exception_arbiter
    import gc_pkg::*;
(
    input  logic                                   local_exc_valid,
    input  logic [XLEN-1:0]                        local_exc_tval,
    input  logic [XLEN-1:0]                        local_exc_pc,
    input  logic [XLEN-1:0]                        issue_pc,
    input  logic [NUM_EXT_EXCEPTIONS-1:0]          exc_valid,
    input  logic [NUM_EXT_EXCEPTIONS-1:0]          exc_possible,
    input  exc_code_t [NUM_EXT_EXCEPTIONS-1:0]     exc_code,
    input  logic [NUM_EXT_EXCEPTIONS-1:0][XLEN-1:0] exc_tval,
    input  logic [NUM_EXT_EXCEPTIONS-1:0][XLEN-1:0] exc_pc,
    output logic                                   gc_exc_valid,
    output logic                                   gc_exc_possible,
    output logic [NUM_EXCEPTIONS-1:0]              gc_exc_source,
    output exc_code_t                              gc_exc_code,
    output logic [XLEN-1:0]                        gc_exc_tval,
    output logic [XLEN-1:0]                        gc_exc_pc
);

    logic [NUM_EXCEPTIONS-1:0]           all_valid;
    exc_code_t [NUM_EXCEPTIONS-1:0]      all_code;
    logic [NUM_EXCEPTIONS-1:0][XLEN-1:0] all_tval;
    logic [NUM_EXCEPTIONS-1:0][XLEN-1:0] all_pc;
    logic [EXC_SRC_W-1:0]                src_idx;

    ////////////////////////////////////////
    // Source table, local entry at index 0
    assign all_valid = {exc_valid, local_exc_valid};
    // Local source only raises illegal instruction
    assign all_code = {exc_code, CODE_ILLEGAL_INST};
    assign all_tval = {exc_tval, local_exc_tval};
    assign all_pc = {exc_pc, local_exc_pc};

    // One-hot to index, ORing the indices of set bits
    always_comb begin
        src_idx = '0;
        for (int i = 0; i < NUM_EXCEPTIONS; i++) begin
            if (all_valid[i]) begin
                src_idx = src_idx | EXC_SRC_W'(i);
            end
        end
    end

    ////////////////////////////////////////
    // Selected record
    assign gc_exc_valid = |all_valid;
    assign gc_exc_source = all_valid;
    assign gc_exc_code = all_code[src_idx];
    assign gc_exc_tval = all_tval[src_idx];
    // Falls back to the issue PC when nothing traps
    assign gc_exc_pc = gc_exc_valid ? all_pc[src_idx] : issue_pc;

    // Stall level, local source is never merely possible
    assign gc_exc_possible = |exc_possible;

endmodule

`default_nettype wire

/* design/gc_state_machine.sv */
// Global control state machine
// Sequences the post-reset clear, then idles until an issued MRET or
// FENCE.I, an exception, a CSR flush or an interrupt needs a front-end
// flush; FENCE.I then drains outstanding stores before fetch resumes
// Hold and clear levels are registered from the next state
`timescale 1ns/1ps
`default_nettype none

module gc_state_machine
    import gc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      issue_new_request,
    input  logic      is_wfi_d,
    input  logic      new_exception,
    input  logic      ifence_r,
    input  logic      gc_exc_valid,
    input  logic      gc_exc_possible,
    input  logic      csr_frontend_flush,
    input  logic      interrupt_pending,
    input  logic      issue_stage_valid,
    input  logic      branch_flush,
    input  logic      outstanding_store,
    output gc_state_t next_state,
    output logic      fetch_hold,
    output logic      issue_hold_core,
    output logic      init_clear,
    output logic      interrupt_taken
);

    gc_state_t             state;
    logic [INIT_CNT_W-1:0] state_counter;
    logic                  init_clear_done;

    ////////////////////////////////////////
    // State register
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RST;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RST: next_state = PRE_CLEAR;
            PRE_CLEAR: next_state = INIT_CLEAR;
            INIT_CLEAR: begin
                if (init_clear_done) begin
                    next_state = IDLE;
                end
            end
            IDLE: begin
                // WFI and trapped instructions do not flush here
                if ((issue_new_request & ~is_wfi_d & ~new_exception) |
                    gc_exc_valid | csr_frontend_flush) begin
                    next_state = PRE_ISSUE_FLUSH;
                end else if (interrupt_pending) begin
                    next_state = WAIT_INTERRUPT;
                end
            end
            WAIT_INTERRUPT: begin
                // Exception wins over the pending interrupt
                if (gc_exc_valid | csr_frontend_flush) begin
                    next_state = PRE_ISSUE_FLUSH;
                end else if (~interrupt_pending) begin
                    next_state = IDLE;
                // Wait for a settled issue stage with a correct PC
                end else if (~gc_exc_possible & issue_stage_valid & ~branch_flush) begin
                    next_state = PRE_ISSUE_FLUSH;
                end
            end
            // Single flush cycle, FENCE.I continues to the store drain
            PRE_ISSUE_FLUSH: next_state = ifence_r ? WAIT_WRITE : IDLE;
            WAIT_WRITE: begin
                if (~outstanding_store) begin
                    next_state = IDLE;
                end
            end
            default: next_state = RST;
        endcase
    end

    // Interrupt accepted only on a clean flush
    assign interrupt_taken = interrupt_pending & (next_state == PRE_ISSUE_FLUSH) &
                             ~gc_exc_valid & ~csr_frontend_flush;

    ////////////////////////////////////////
    // Init clear counter
    // Top bit set after INIT_CLEAR_DEPTH cycles
    always_ff @(posedge clk) begin
        if (rst || (next_state == IDLE)) begin
            state_counter <= '0;
        end else if (next_state == INIT_CLEAR) begin
            state_counter <= state_counter + 1'b1;
        end
    end

    assign init_clear_done = state_counter[INIT_CNT_W-1];

    ////////////////////////////////////////
    // Registered hold levels
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_hold <= 1'b0;
            issue_hold_core <= 1'b0;
            init_clear <= 1'b0;
        end else begin
            fetch_hold <= next_state inside {PRE_CLEAR, INIT_CLEAR, PRE_ISSUE_FLUSH, WAIT_WRITE};
            // Issue also stops while an interrupt waits
            issue_hold_core <= next_state inside {PRE_CLEAR, INIT_CLEAR, WAIT_INTERRUPT,
                                                  PRE_ISSUE_FLUSH, WAIT_WRITE};
            init_clear <= (next_state == INIT_CLEAR);
        end
    end

endmodule

`default_nettype wire

/* design/gc_pc_select.sv */
// Global control PC select
// Two-cycle override for traps, returns and flushes: the flush cycle
// empties the front end and the captured target is fetched next
`timescale 1ns/1ps
`default_nettype none

module gc_pc_select
    import gc_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  gc_state_t       next_state,
    input  logic            gc_exc_valid,
    input  logic            interrupt_taken,
    input  logic            issue_new_request,
    input  logic            is_mret_d,
    input  logic [XLEN-1:0] exception_target_pc,
    input  logic [XLEN-1:0] mepc,
    input  logic [XLEN-1:0] next_pc,
    output logic            pc_override,
    output logic [XLEN-1:0] pc
);

    ////////////////////////////////////////
    // Override level
    // Also held through the reset clear
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_override <= 1'b0;
        end else begin
            pc_override <= next_state inside {PRE_ISSUE_FLUSH, INIT_CLEAR};
        end
    end

    // Target capture, traps take priority
    always_ff @(posedge clk) begin
        if (gc_exc_valid | interrupt_taken) begin
            pc <= exception_target_pc;
        end else if (issue_new_request) begin
            // FENCE.I and CSR flush resume at the next instruction
            pc <= is_mret_d ? mepc : next_pc;
        end
    end

endmodule

`default_nettype wire

/* design/gc_unit.sv */
// Global control unit, machine/user build
// Decodes MRET, WFI and FENCE.I, checks privilege at issue, arbitrates
// exceptions, accepts interrupts and drives fetch/issue holds and the
// PC override; always accepts its instructions
`timescale 1ns/1ps
`default_nettype none

module gc_unit
    import gc_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    rst,
    // Decode and issue
    input  logic [XLEN-1:0]                         decode_instruction,
    input  logic                                    issue_stage_ready,
    input  logic                                    issue_new_request,
    input  logic [XLEN-1:0]                         issue_instruction,
    input  logic [XLEN-1:0]                         issue_pc,
    input  logic                                    issue_stage_valid,
    input  priv_t                                   privilege,
    input  logic                                    branch_flush,
    output logic                                    unit_needed,
    // External exception sources
    input  logic [NUM_EXT_EXCEPTIONS-1:0]           exc_valid,
    input  logic [NUM_EXT_EXCEPTIONS-1:0]           exc_possible,
    input  exc_code_t [NUM_EXT_EXCEPTIONS-1:0]      exc_code,
    input  logic [NUM_EXT_EXCEPTIONS-1:0][XLEN-1:0] exc_tval,
    input  logic [NUM_EXT_EXCEPTIONS-1:0][XLEN-1:0] exc_pc,
    // Targets, CSR and memory status
    input  logic [XLEN-1:0]                         exception_target_pc,
    input  logic [XLEN-1:0]                         mepc,
    input  logic [XLEN-1:0]                         next_pc,
    input  logic                                    interrupt_pending,
    input  logic                                    csr_frontend_flush,
    input  logic                                    outstanding_store,
    // Global controls
    output logic                                    fetch_flush,
    output logic                                    fetch_hold,
    output logic                                    issue_hold,
    output logic                                    init_clear,
    output logic                                    fetch_ifence,
    output logic                                    mret,
    output logic                                    interrupt_taken,
    output logic                                    pc_override,
    output logic [XLEN-1:0]                         pc,
    // Selected exception
    output logic                                    gc_exc_valid,
    output logic [NUM_EXCEPTIONS-1:0]               gc_exc_source,
    output exc_code_t                               gc_exc_code,
    output logic [XLEN-1:0]                         gc_exc_tval,
    output logic [XLEN-1:0]                         gc_exc_pc
);

    logic            is_mret_d;
    logic            is_wfi_d;
    logic            is_ifence_d;
    logic            new_exception;
    logic            ifence_r;
    logic            local_exc_valid;
    logic [XLEN-1:0] local_exc_tval;
    logic [XLEN-1:0] local_exc_pc;
    logic            gc_exc_possible;
    logic            issue_hold_core;
    gc_state_t       next_state;

    ////////////////////////////////////////
    // Blocks, nets share the port names
    gc_decode i_decode (.*);
    gc_issue_check i_issue_check (.*);
    gc_exception_arbiter i_exception_arbiter (.*);
    gc_state_machine i_state_machine (.*);
    gc_pc_select i_pc_select (.*);

    // Front end flushes on a branch miss or an override
    assign fetch_flush = branch_flush | pc_override;
    // A possible exception stalls issue in the same cycle
    assign issue_hold = issue_hold_core | gc_exc_possible;

endmodule

`default_nettype wire

/* bench/gc_clock_gen.sv */
// Testbench clock and reset
// 10 ns clock with a synchronous reset held high for the first four
// rising edges and released on a falling edge
`timescale 1ns/1ps
`default_nettype none

module gc_clock_gen (
    output logic clk,
    output logic rst
);

    // 5 ns half period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        // Release away from the sampling edge
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* bench/gc_unit_tb.sv */
// Global control unit testbench
// Runs reset and init clear, decode, MRET in both modes, external
// exceptions, FENCE.I with a store drain and interrupt acceptance
// Inputs change on the falling edge and arbiter outputs are compared
// against a reference model at every rising edge
`timescale 1ns/1ps
`default_nettype none

module gc_unit_tb
    import gc_pkg::*;
();

    typedef struct packed {
        logic                      valid;
        logic [NUM_EXCEPTIONS-1:0] source;
        exc_code_t                 code;
        logic [XLEN-1:0]           tval;
        logic [XLEN-1:0]           pc;
    } exc_rec_t;

    localparam int DECODE_WORDS = 64;
    localparam int EXC_ROUNDS = 24;
    // Cycle budget per test summed for the watchdog
    localparam int TOTAL_CYCLES = (INIT_CLEAR_DEPTH + 12) + (DECODE_WORDS + 2) + 10 +
                                  (3 * EXC_ROUNDS + 2) + 16 + 14;

    ////////////////////////////////////////
    // DUT connections
    logic                                    clk;
    logic                                    rst;
    logic [XLEN-1:0]                         decode_instruction, issue_instruction, issue_pc;
    logic                                    issue_stage_ready, issue_new_request;
    logic                                    issue_stage_valid, branch_flush;
    priv_t                                   privilege;
    logic [NUM_EXT_EXCEPTIONS-1:0]           exc_valid, exc_possible;
    exc_code_t [NUM_EXT_EXCEPTIONS-1:0]      exc_code;
    logic [NUM_EXT_EXCEPTIONS-1:0][XLEN-1:0] exc_tval, exc_pc;
    logic [XLEN-1:0]                         exception_target_pc, mepc, next_pc;
    logic                                    interrupt_pending, csr_frontend_flush;
    logic                                    outstanding_store;
    logic                                    unit_needed, fetch_flush, fetch_hold, issue_hold;
    logic                                    init_clear, fetch_ifence, mret;
    logic                                    interrupt_taken, pc_override;
    logic [XLEN-1:0]                         pc, gc_exc_tval, gc_exc_pc;
    logic                                    gc_exc_valid;
    logic [NUM_EXCEPTIONS-1:0]               gc_exc_source;
    exc_code_t                               gc_exc_code;

    // Checker state
    int              errors = 0;
    int              tests_run = 0;
    int              tests_failed = 0;
    logic            cmp_on = 1'b0;
    // Local trap record the stimulus expects at the next edge
    logic            exp_local = 1'b0;
    logic [XLEN-1:0] exp_local_tval;
    logic [XLEN-1:0] exp_local_pc;
    exc_rec_t        cmp_rec;

    gc_clock_gen i_clock_gen (.clk(clk), .rst(rst));

    gc_unit i_dut (.*);

    ////////////////////////////////////////
    // Reference model
    // One-hot sources with the local entry at index 0
    function automatic exc_rec_t expect_exception(
        input logic                                    loc_valid,
        input logic [XLEN-1:0]                         loc_tval,
        input logic [XLEN-1:0]                         loc_pc,
        input logic [NUM_EXT_EXCEPTIONS-1:0]           ext_valid,
        input exc_code_t [NUM_EXT_EXCEPTIONS-1:0]      ext_code,
        input logic [NUM_EXT_EXCEPTIONS-1:0][XLEN-1:0] ext_tval,
        input logic [NUM_EXT_EXCEPTIONS-1:0][XLEN-1:0] ext_pc,
        input logic [XLEN-1:0]                         ipc
    );
        exc_rec_t rec;
        rec = '0;
        rec.valid = loc_valid | (|ext_valid);
        rec.source = {ext_valid, loc_valid};
        // No trap leaves the issue PC
        rec.pc = ipc;
        // MRET from user mode is the only local cause
        if (loc_valid) begin
            rec.code = CODE_ILLEGAL_INST;
            rec.tval = loc_tval;
            rec.pc = loc_pc;
        end
        for (int i = 0; i < NUM_EXT_EXCEPTIONS; i++) begin
            if (ext_valid[i]) begin
                rec.code = ext_code[i];
                rec.tval = ext_tval[i];
                rec.pc = ext_pc[i];
            end
        end
        return rec;
    endfunction

    // Override target with the trap vector first and mepc for a return
    function automatic logic [XLEN-1:0] expect_pc(input logic trap, input logic is_return);
        if (trap) return exception_target_pc;
        return is_return ? mepc : next_pc;
    endfunction

    // Causes an external source may raise
    function automatic exc_code_t random_cause(input int unsigned sel);
        case (sel % 8)
            0: return CODE_INST_MISALIGNED;
            1: return CODE_INST_FAULT;
            2: return CODE_ILLEGAL_INST;
            3: return CODE_BREAKPOINT;
            4: return CODE_LOAD_FAULT;
            5: return CODE_STORE_FAULT;
            6: return CODE_ECALL_U;
            default: return CODE_ECALL_M;
        endcase
    endfunction

    ////////////////////////////////////////
    // Reporting
    task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                   input logic [XLEN-1:0] exp);
        errors++;
        $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("failure: %s", what);
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests_run++;
        if (errors != err_start) tests_failed++;
        $display("test %s %s", name, (errors == err_start) ? "ok" : "FAILED");
    endtask

    // Word presented to decode one cycle before its issue strobe
    // Returns on the falling edge after the strobe edge
    task automatic issue_instr(input logic [XLEN-1:0] word, input priv_t priv);
        @(negedge clk);
        decode_instruction = word;
        issue_stage_ready = 1'b1;
        @(negedge clk);
        issue_stage_ready = 1'b0;
        issue_new_request = 1'b1;
        issue_instruction = word;
        issue_pc = $urandom;
        privilege = priv;
        @(negedge clk);
        issue_new_request = 1'b0;
    endtask

    ////////////////////////////////////////
    // Compare process
    // Sampled at the rising edge before any register updates
    always @(posedge clk) begin
        if (cmp_on) begin
            cmp_rec = expect_exception(exp_local, exp_local_tval, exp_local_pc, exc_valid,
                                       exc_code, exc_tval, exc_pc, issue_pc);
            if (gc_exc_valid !== cmp_rec.valid)
                report_mismatch("gc_exc_valid", gc_exc_valid, cmp_rec.valid);
            if (gc_exc_source !== cmp_rec.source)
                report_mismatch("gc_exc_source", gc_exc_source, cmp_rec.source);
            if (gc_exc_pc !== cmp_rec.pc)
                report_mismatch("gc_exc_pc", gc_exc_pc, cmp_rec.pc);
            // Code and tval only mean something with a trap
            if (cmp_rec.valid && gc_exc_code !== cmp_rec.code)
                report_mismatch("gc_exc_code", gc_exc_code, cmp_rec.code);
            if (cmp_rec.valid && gc_exc_tval !== cmp_rec.tval)
                report_mismatch("gc_exc_tval", gc_exc_tval, cmp_rec.tval);
            if ((|exc_possible) && issue_hold !== 1'b1)
                report_failure("issue_hold low while an exception is possible");
        end
    end

    // Watchdog
    initial begin
        #((TOTAL_CYCLES + 50) * 10);
        $display("failure: run did not finish within %0d cycles", TOTAL_CYCLES + 50);
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////
    // Stimulus
    initial begin
        int              start;
        int              hold_cycles;
        logic [XLEN-1:0] w;
        logic            seen;
        start = $urandom(32'h8344);
        {decode_instruction, issue_instruction, issue_pc} = '0;
        {exception_target_pc, mepc, next_pc} = '0;
        {issue_stage_ready, issue_new_request, issue_stage_valid, branch_flush} = '0;
        {exc_valid, exc_possible, exc_code, exc_tval, exc_pc} = '0;
        {interrupt_pending, csr_frontend_flush, outstanding_store} = '0;
        privilege = PRIV_MACHINE;

        // Reset and init clear
        @(negedge rst);
        start = errors;
        if (init_clear || mret || fetch_ifence) report_failure("pulse high right after reset");
        seen = 1'b0;
        for (int c = 0; c < INIT_CLEAR_DEPTH + 6; c++) begin
            @(negedge clk);
            if (init_clear && !pc_override) report_failure("pc_override low during init clear");
            seen = seen | init_clear;
            if (seen && !init_clear && !fetch_hold && !issue_hold) break;
        end
        if (!seen || init_clear || fetch_hold || issue_hold)
            report_failure("init clear did not end with holds released");
        cmp_on = 1'b1;
        finish_test("reset", start);

        // Decode over fixed encodings and random words
        start = errors;
        for (int i = 0; i < DECODE_WORDS; i++) begin
            @(negedge clk);
            case (i % 4)
                0: w = INSTR_MRET;
                1: w = INSTR_WFI;
                // FENCE.I with random rd, rs1 and imm
                2: w = ($urandom & ~32'h0000_707f) | 32'h0000_100f;
                default: w = $urandom;
            endcase
            decode_instruction = w;
            // Branch miss in idle flushes fetch on its own
            branch_flush = (i % 4 == 1);
            #1;
            seen = (w == INSTR_MRET) || (w == INSTR_WFI) ||
                   (w[6:0] == 7'b000_1111 && w[14:12] == 3'b001);
            if (unit_needed !== seen) report_mismatch("unit_needed", unit_needed, seen);
            if (fetch_flush !== branch_flush)
                report_mismatch("fetch_flush", fetch_flush, branch_flush);
        end
        finish_test("decode", start);

        // MRET in machine mode returns to mepc
        start = errors;
        mepc = $urandom;
        issue_instr(INSTR_MRET, PRIV_MACHINE);
        if (mret !== 1'b1) report_mismatch("mret", mret, 1'b1);
        if (pc_override !== 1'b1) report_mismatch("pc_override", pc_override, 1'b1);
        if (fetch_flush !== 1'b1) report_mismatch("fetch_flush", fetch_flush, 1'b1);
        if (pc !== expect_pc(1'b0, 1'b1)) report_mismatch("pc", pc, expect_pc(1'b0, 1'b1));
        @(negedge clk);
        if (mret || pc_override || fetch_flush)
            report_failure("mret, pc_override or fetch_flush held past one cycle");
        finish_test("mret_m", start);

        // MRET in user mode traps as an illegal instruction
        start = errors;
        exception_target_pc = $urandom;
        issue_instr(INSTR_MRET, PRIV_USER);
        exp_local = 1'b1;
        exp_local_tval = INSTR_MRET;
        exp_local_pc = issue_pc;
        if (mret) report_failure("mret pulsed for a user-mode MRET");
        @(negedge clk);
        exp_local = 1'b0;
        privilege = PRIV_MACHINE;
        if (mret || !pc_override) report_failure("user-mode MRET did not trap");
        if (pc !== expect_pc(1'b1, 1'b1)) report_mismatch("pc", pc, expect_pc(1'b1, 1'b1));
        @(negedge clk);
        finish_test("mret_u", start);

        // External exceptions that are one-hot or absent
        start = errors;
        for (int i = 0; i < EXC_ROUNDS; i++) begin
            @(negedge clk);
            exc_valid = '0;
            if (i % 4 != 3) exc_valid[$urandom % NUM_EXT_EXCEPTIONS] = 1'b1;
            exc_possible = NUM_EXT_EXCEPTIONS'($urandom);
            for (int s = 0; s < NUM_EXT_EXCEPTIONS; s++) begin
                exc_code[s] = random_cause($urandom);
                exc_tval[s] = $urandom;
                exc_pc[s] = $urandom;
            end
            issue_pc = $urandom;
            exception_target_pc = $urandom;
            @(negedge clk);
            if ((|exc_valid) && !pc_override) report_failure("no pc_override after exception");
            if ((|exc_valid) && pc !== expect_pc(1'b1, 1'b0))
                report_mismatch("pc", pc, expect_pc(1'b1, 1'b0));
            exc_valid = '0;
            exc_possible = '0;
            @(negedge clk);
        end
        finish_test("exceptions", start);

        // FENCE.I waits for the store drain
        start = errors;
        next_pc = $urandom;
        outstanding_store = 1'b1;
        issue_instr(INSTR_FENCE_I, PRIV_MACHINE);
        if (fetch_ifence !== 1'b1) report_mismatch("fetch_ifence", fetch_ifence, 1'b1);
        if (pc !== expect_pc(1'b0, 1'b0)) report_mismatch("pc", pc, expect_pc(1'b0, 1'b0));
        hold_cycles = 2 + $urandom % 8;
        for (int c = 0; c < hold_cycles; c++) begin
            @(negedge clk);
            if (fetch_ifence) report_failure("fetch_ifence held past one cycle");
            if (!fetch_hold || !issue_hold) report_failure("holds dropped with a store pending");
        end
        outstanding_store = 1'b0;
        @(negedge clk);
        if (fetch_hold !== 1'b0) report_mismatch("fetch_hold", fetch_hold, 1'b0);
        finish_test("fence_i", start);

        // Interrupt blocked by a possible exception
        start = errors;
        exception_target_pc = $urandom;
        exc_possible[1] = 1'b1;
        issue_stage_valid = 1'b1;
        interrupt_pending = 1'b1;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            if (interrupt_taken) report_failure("interrupt taken while an exception is possible");
        end
        exc_possible = '0;
        seen = 1'b0;
        for (int c = 0; c < 4 && !seen; c++) begin
            #1;
            seen = interrupt_taken;
            if (!seen) @(negedge clk);
        end
        if (!seen) report_failure("interrupt not taken after the stall cleared");
        @(negedge clk);
        interrupt_pending = 1'b0;
        if (!pc_override) report_failure("no pc_override after the interrupt");
        if (pc !== expect_pc(1'b1, 1'b0)) report_mismatch("pc", pc, expect_pc(1'b1, 1'b0));
        @(negedge clk);
        finish_test("interrupt", start);

        $display("tests run %0d, failed %0d, error count %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
design/gc_pkg.sv
design/gc_decode.sv
design/gc_issue_check.sv
design/gc_exception_arbiter.sv
design/gc_state_machine.sv
design/gc_pc_select.sv
design/gc_unit.sv
bench/gc_clock_gen.sv
bench/gc_unit_tb.sv
